// ==== Makefile ====
# Verilator build and run for the execute-stage ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_exu_alu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/exu_alu_checker.sv ====
// Execute-stage ALU checker
// Bound into exu_alu, holds the RV32 result rules and the
// handshake rules as concurrent assertions

`default_nettype none

module exu_alu_checker import exu_pkg::*, alu_pkg::*; (
  input wire         clk,
  input wire         i_rst_n,
  input wire         i_valid,
  input wire         o_ready,        // Same names as the DUT ports
  input wire issue_t i_issue,
  input wire         o_cmt_valid,
  input wire         i_cmt_ready,
  input wire cmt_t   o_cmt,
  input wire         o_wbck_valid,
  input wire         i_wbck_ready,
  input wire wbck_t  o_wbck
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned        err_cnt = 0;
  logic               excp;
  logic               need_wbck;
  logic               is_arith;
  logic               is_bjp;
  logic               is_jump;
  logic [XLEN-1:0]    op2;
  logic [XLEN-1:0]    exp_wdat;
  logic               exp_rslv;
  logic [PC_SIZE-1:0] exp_link;

  assign excp      = i_issue.ilegl | i_issue.buserr | i_issue.misalgn;
  assign need_wbck = i_issue.rdwen & ~excp;
  assign is_arith  = ~excp & (i_issue.info.grp == GRP_ALU)
                   & !(i_issue.info.alu_op inside {ALU_ECALL, ALU_EBREAK, ALU_WFI});
  assign is_bjp    = ~excp & (i_issue.info.grp == GRP_BJP);
  assign is_jump   = is_bjp & (i_issue.info.bjp_op == BJP_JUMP);
  assign exp_link  = i_issue.pc + (i_issue.info.rv32 ? PC_SIZE'(4) : PC_SIZE'(2));

  //////////////////////////////
  // Reference results
  always_comb begin
    op2 = i_issue.info.op2imm ? i_issue.imm : i_issue.rs2;
    case (i_issue.info.alu_op)
      ALU_ADD:  exp_wdat = i_issue.rs1 + op2;
      ALU_SUB:  exp_wdat = i_issue.rs1 - op2;
      ALU_XOR:  exp_wdat = i_issue.rs1 ^ op2;
      ALU_SLL:  exp_wdat = i_issue.rs1 << op2[4:0];
      ALU_SRL:  exp_wdat = i_issue.rs1 >> op2[4:0];
      ALU_SRA:  exp_wdat = $signed(i_issue.rs1) >>> op2[4:0];
      ALU_OR:   exp_wdat = i_issue.rs1 | op2;
      ALU_AND:  exp_wdat = i_issue.rs1 & op2;
      ALU_SLT:  exp_wdat = XLEN'($signed(i_issue.rs1) < $signed(op2));
      ALU_SLTU: exp_wdat = XLEN'(i_issue.rs1 < op2);
      ALU_LUI:  exp_wdat = i_issue.imm;
      default:  exp_wdat = '0;
    endcase
    case (i_issue.info.bjp_op)
      BJP_BEQ:  exp_rslv = (i_issue.rs1 == i_issue.rs2);
      BJP_BNE:  exp_rslv = (i_issue.rs1 != i_issue.rs2);
      BJP_BLT:  exp_rslv = ($signed(i_issue.rs1) < $signed(i_issue.rs2));
      BJP_BGE:  exp_rslv = ($signed(i_issue.rs1) >= $signed(i_issue.rs2));
      BJP_BLTU: exp_rslv = (i_issue.rs1 < i_issue.rs2);
      BJP_BGEU: exp_rslv = (i_issue.rs1 >= i_issue.rs2);
      default:  exp_rslv = 1'b1;   // Jump
    endcase
  end

  //////////////////////////////
  // Results and flags
  a_alu_result: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wbck_valid && is_arith) |-> (o_wbck.wdat == exp_wdat && o_wbck.rdidx == i_issue.rdidx))
    else begin err_cnt++; $error("Fail %0t: ALU write-back data or rdidx wrong", $time); end

  a_jump_link: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wbck_valid && is_jump) |-> (o_wbck.wdat == exp_link && o_wbck.rdidx == i_issue.rdidx))
    else begin err_cnt++; $error("Fail %0t: jump link value wrong", $time); end

  a_bjp_commit: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && is_bjp) |->
      (o_cmt.bjp && o_cmt.bjp_rslv == exp_rslv && o_cmt.bjp_prdt == i_issue.info.bprdt))
    else begin err_cnt++; $error("Fail %0t: branch commit fields wrong", $time); end

  a_cmt_copy: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_valid |->
      (o_cmt.pc == i_issue.pc && o_cmt.pc_vld == i_issue.pc_vld &&
       o_cmt.imm == i_issue.imm && o_cmt.rv32 == i_issue.info.rv32))
    else begin err_cnt++; $error("Fail %0t: commit pc, imm or rv32 wrong", $time); end

  a_sys_flags: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && !excp) |->
      (o_cmt.ecall  == (!is_bjp && i_issue.info.alu_op == ALU_ECALL) &&
       o_cmt.ebreak == (!is_bjp && i_issue.info.alu_op == ALU_EBREAK) &&
       o_cmt.wfi    == (!is_bjp && i_issue.info.alu_op == ALU_WFI)))
    else begin err_cnt++; $error("Fail %0t: system flags wrong", $time); end

  a_fetch_excp: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && excp) |->
      (!o_cmt.bjp && !o_cmt.ecall && !o_cmt.ebreak && !o_cmt.wfi && !o_wbck_valid &&
       o_cmt.ifu_ilegl == i_issue.ilegl && o_cmt.ifu_buserr == i_issue.buserr &&
       o_cmt.ifu_misalgn == i_issue.misalgn))
    else begin err_cnt++; $error("Fail %0t: fetch exception commit wrong", $time); end

  //////////////////////////////
  // Handshake
  a_commit_only: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && !need_wbck) |-> (o_cmt_valid && !o_wbck_valid))
    else begin err_cnt++; $error("Fail %0t: commit-only instruction wrong", $time); end

  a_wbck_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && need_wbck && !i_wbck_ready) |-> (!o_cmt_valid && !o_ready))
    else begin err_cnt++; $error("Fail %0t: commit fired without write-back", $time); end

  a_cmt_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && !i_cmt_ready) |-> (!o_wbck_valid && !o_ready))
    else begin err_cnt++; $error("Fail %0t: write-back fired without commit", $time); end

  a_both_fire: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && i_cmt_ready && i_wbck_ready) |->
      (o_cmt_valid && o_ready && o_wbck_valid == need_wbck))
    else begin err_cnt++; $error("Fail %0t: valids not raised together", $time); end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
// Testbench clock and reset
// 10 ns clock, active-low reset held for a set number of cycles

`default_nettype none

module tb_clkgen #(
  parameter int RST_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial o_clk = 1'b0;
  always #5 o_clk = ~o_clk;

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;   // Released off the edge
  end

endmodule

`default_nettype wire

// ==== bench/tb_exu_alu.sv ====
// Execute-stage ALU testbench
// Issues ALU, branch, system and fetch-exception instructions,
// with and without back-pressure, while the bound checker judges

`default_nettype none

module tb_exu_alu import exu_pkg::*, alu_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 50;

  logic   clk;
  logic   rst_n;
  logic   i_valid;
  logic   o_ready;
  issue_t i_issue;
  logic   o_cmt_valid;
  logic   i_cmt_ready;
  cmt_t   o_cmt;
  logic   o_wbck_valid;
  logic   i_wbck_ready;
  wbck_t  o_wbck;
  integer seed = 32'h50b6_2697;

  tb_clkgen #(.RST_CYCLES(10)) u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

  exu_alu DUT (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_issue      (i_issue),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  bind exu_alu exu_alu_checker u_checker (
    .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .o_ready(o_ready),
    .i_issue(i_issue), .o_cmt_valid(o_cmt_valid), .i_cmt_ready(i_cmt_ready),
    .o_cmt(o_cmt), .o_wbck_valid(o_wbck_valid), .i_wbck_ready(i_wbck_ready),
    .o_wbck(o_wbck)
  );

  task automatic abort_run(input string why);
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  // Random operands on a plain 32-bit ALU instruction without rd
  function automatic issue_t base_issue();
    issue_t          iss;
    logic [XLEN-1:0] w;
    iss           = '0;
    iss.rs1       = rand_word();
    iss.rs2       = rand_word();
    iss.imm       = rand_word();
    iss.pc        = rand_word();
    w             = rand_word();
    iss.rdidx     = w[RFIDX_WIDTH-1:0];
    iss.pc_vld    = w[RFIDX_WIDTH];
    iss.info.grp  = GRP_ALU;
    iss.info.rv32 = 1'b1;
    return iss;
  endfunction

  // Hold one instruction until taken with readies low for the stall counts
  task automatic send(input issue_t iss, input int stall_wbck, input int stall_cmt);
    int   n;
    logic done;
    done         = 1'b0;
    i_valid      = 1'b1;
    i_issue      = iss;
    i_wbck_ready = (stall_wbck == 0);
    i_cmt_ready  = (stall_cmt == 0);
    for (n = 1; n <= WAIT_LIMIT && !done; n++) begin
      @(posedge clk);
      done = o_ready;
      #1;
      if (n >= stall_wbck) i_wbck_ready = 1'b1;
      if (n >= stall_cmt) i_cmt_ready = 1'b1;
    end
    i_valid = 1'b0;
    if (!done) abort_run("Timeout waiting for o_ready on an issued instruction");
  endtask

  always @(posedge clk) begin
    if (DUT.u_checker.err_cnt != 0) abort_run("Checker assertion failed");
  end

  initial begin
    issue_t iss;
    int     k;
    int     j;
    int     n;
    i_valid      = 1'b0;
    i_issue      = '0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    for (n = 0; n < WAIT_LIMIT && !rst_n; n++) @(posedge clk);
    if (!rst_n) abort_run("Timeout waiting for reset release");
    #1;

    //////////////////////////////
    // Arithmetic, logic, shifts, LUI
    for (k = 0; k <= 10; k++) begin
      for (j = 0; j < 4; j++) begin
        iss             = base_issue();
        iss.info.alu_op = alu_op_e'(4'(k));
        iss.info.op2imm = j[0];
        iss.rdwen       = 1'b1;
        send(iss, 0, 0);
      end
    end

    // Conditional branches with equal operands on every other one
    for (k = 0; k <= 5; k++) begin
      for (j = 0; j < 6; j++) begin
        iss             = base_issue();
        iss.info.grp    = GRP_BJP;
        iss.info.bjp_op = bjp_op_e'(3'(k));
        iss.info.bprdt  = j[1];
        if (j[0]) iss.rs2 = iss.rs1;
        send(iss, 0, 0);
      end
    end

    for (j = 0; j < 4; j++) begin   // Jumps in 16 and 32 bit form
      iss             = base_issue();
      iss.info.grp    = GRP_BJP;
      iss.info.bjp_op = BJP_JUMP;
      iss.info.rv32   = j[0];
      iss.rdwen       = 1'b1;
      send(iss, 0, 0);
    end

    //////////////////////////////
    // System ops and commit-only ADD
    for (k = 11; k <= 13; k++) begin
      iss             = base_issue();
      iss.info.alu_op = alu_op_e'(4'(k));
      send(iss, 0, 0);
    end
    iss = base_issue();
    send(iss, 0, 3);

    for (j = 0; j < 6; j++) begin   // Fetch exceptions
      iss             = base_issue();
      iss.info.grp    = grp_e'(j[0]);
      iss.info.alu_op = alu_op_e'(4'(11 + j % 3));
      iss.rdwen       = 1'b1;
      iss.ilegl       = (j % 3 == 0);
      iss.buserr      = (j % 3 == 1);
      iss.misalgn     = (j % 3 == 2);
      send(iss, 0, 0);
    end

    // Back-pressure on each side and on both
    iss       = base_issue();
    iss.rdwen = 1'b1;
    send(iss, 3, 0);
    send(iss, 0, 3);
    send(iss, 2, 4);

    repeat (3) @(posedge clk);
    #1;
    if (DUT.u_checker.err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("Checker assertion failed");
    end
  end

endmodule

`default_nettype wire

// ==== source/alu_bjp.sv ====
// Branch and jump unit
// Asks the datapath for a compare or the link add and
// resolves the branch direction

`default_nettype none

module alu_bjp import exu_pkg::*, alu_pkg::*; (
  input  wire             i_vld,
  input  wire issue_t     i_issue,
  output dpath_req_t      o_req,
  input  wire dpath_rsp_t i_rsp,
  output logic [XLEN-1:0] o_wdat,
  output logic            o_bjp,
  output logic            o_rslv
);

  bjp_op_e         op;
  dpath_op_e       cmp_op;
  logic            is_jump;
  logic [XLEN-1:0] link_ofs;

  assign op      = i_issue.info.bjp_op;
  assign is_jump = (op == BJP_JUMP);

  always_comb begin
    case (op)
      BJP_BEQ:  cmp_op = DP_CMP_EQ;
      BJP_BNE:  cmp_op = DP_CMP_NE;
      BJP_BLT:  cmp_op = DP_CMP_LT;
      BJP_BGE:  cmp_op = DP_CMP_GE;
      BJP_BLTU: cmp_op = DP_CMP_LTU;
      BJP_BGEU: cmp_op = DP_CMP_GEU;
      default:  cmp_op = DP_CMP_EQ;
    endcase
  end

  // Next sequential pc, 16-bit instructions step by 2
  assign link_ofs = i_issue.info.rv32 ? XLEN'(4) : XLEN'(2);

  assign o_req.req = i_vld;
  assign o_req.op  = is_jump ? DP_ADD : cmp_op;
  assign o_req.op1 = is_jump ? i_issue.pc : i_issue.rs1;
  assign o_req.op2 = is_jump ? link_ofs : i_issue.rs2;

  assign o_wdat = i_rsp.res;   // Link value
  assign o_bjp  = i_vld;
  assign o_rslv = is_jump | i_rsp.cmp_res;   // Jumps always taken

endmodule

`default_nettype wire

// ==== source/alu_dispatch.sv ====
// ALU dispatch and result arbitration
// Routes an instruction to one unit, picks its result and
// runs the commit / write-back handshake

`default_nettype none

module alu_dispatch import exu_pkg::*, alu_pkg::*; (
  input  wire             i_valid,
  output logic            o_ready,
  input  wire issue_t     i_issue,
  output logic            o_alu_vld,
  output logic            o_bjp_vld,
  input  wire [XLEN-1:0]  i_alu_wdat,
  input  wire             i_alu_ecall,
  input  wire             i_alu_ebreak,
  input  wire             i_alu_wfi,
  input  wire [XLEN-1:0]  i_bjp_wdat,
  input  wire             i_bjp_bjp,
  input  wire             i_bjp_rslv,
  output logic            o_cmt_valid,
  input  wire             i_cmt_ready,
  output cmt_t            o_cmt,
  output logic            o_wbck_valid,
  input  wire             i_wbck_ready,
  output wbck_t           o_wbck
);

  logic ifu_excp;
  logic sel_alu;
  logic sel_bjp;
  logic need_wbck;

  //////////////////////////////
  // Group decode
  assign ifu_excp = i_issue.ilegl | i_issue.buserr | i_issue.misalgn;
  assign sel_alu  = ~ifu_excp & (i_issue.info.grp == GRP_ALU);
  assign sel_bjp  = ~ifu_excp & (i_issue.info.grp == GRP_BJP);

  assign o_alu_vld = i_valid & sel_alu;
  assign o_bjp_vld = i_valid & sel_bjp;

  // Zero data on a fetch exception, which also counts as error
  assign o_wbck.wdat  = ({XLEN{sel_alu}} & i_alu_wdat)
                      | ({XLEN{sel_bjp}} & i_bjp_wdat);
  assign o_wbck.rdidx = i_issue.rdidx;

  //////////////////////////////
  // Handshake, commit always, write-back only for rd without error
  assign need_wbck    = i_issue.rdwen & ~ifu_excp;
  assign o_ready      = i_cmt_ready & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = need_wbck & i_valid & i_cmt_ready;
  assign o_cmt_valid  = i_valid & (~need_wbck | i_wbck_ready);

  assign o_cmt.pc          = i_issue.pc;
  assign o_cmt.pc_vld      = i_issue.pc_vld;
  assign o_cmt.imm         = i_issue.imm;
  assign o_cmt.rv32        = i_issue.info.rv32;
  assign o_cmt.bjp         = sel_bjp & i_bjp_bjp;
  assign o_cmt.bjp_prdt    = sel_bjp & i_issue.info.bprdt;
  assign o_cmt.bjp_rslv    = sel_bjp & i_bjp_rslv;
  assign o_cmt.ecall       = sel_alu & i_alu_ecall;
  assign o_cmt.ebreak      = sel_alu & i_alu_ebreak;
  assign o_cmt.wfi         = sel_alu & i_alu_wfi;
  assign o_cmt.ifu_misalgn = i_issue.misalgn;   // Straight from fetch
  assign o_cmt.ifu_buserr  = i_issue.buserr;
  assign o_cmt.ifu_ilegl   = i_issue.ilegl;

endmodule

`default_nettype wire

// ==== source/alu_dpath.sv ====
// Shared ALU datapath
// One 33-bit adder, one shifter and the logic ops, serving
// the regular unit and the branch unit

`default_nettype none

module alu_dpath import exu_pkg::*, alu_pkg::*; (
  input  wire dpath_req_t i_rglr_req,
  input  wire dpath_req_t i_bjp_req,
  output dpath_rsp_t      o_rsp
);

  localparam int SHW = $clog2(XLEN);

  dpath_req_t      req;
  logic            sub_op;
  logic            sgn_op;
  logic [XLEN:0]   add_op1;
  logic [XLEN:0]   add_op2;
  logic [XLEN:0]   add_res;
  logic            lt;
  logic [XLEN-1:0] xor_res;
  logic            eq;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] sh_in;
  logic [XLEN-1:0] sh_out;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] sra_res;

  assign req = i_rglr_req.req ? i_rglr_req : i_bjp_req;

  //////////////////////////////
  // Adder, sign bit of a 33-bit difference gives less-than
  assign sub_op = req.op inside {DP_SUB, DP_SLT, DP_SLTU, DP_CMP_LT,
                                 DP_CMP_GE, DP_CMP_LTU, DP_CMP_GEU};
  assign sgn_op = req.op inside {DP_SLT, DP_CMP_LT, DP_CMP_GE};

  assign add_op1 = {sgn_op & req.op1[XLEN-1], req.op1};
  assign add_op2 = {sgn_op & req.op2[XLEN-1], req.op2};
  assign add_res = add_op1 + (sub_op ? ~add_op2 : add_op2) + (XLEN+1)'(sub_op);
  assign lt      = add_res[XLEN];

  assign xor_res = req.op1 ^ req.op2;
  assign eq      = (xor_res == '0);

  //////////////////////////////
  // Right shifter, left shift by bit reversal
  assign shamt = req.op2[SHW-1:0];

  always_comb begin
    sh_in = req.op1;
    if (req.op == DP_SLL) begin
      sh_in = {<<{req.op1}};
    end
    sh_out  = sh_in >> shamt;
    sll_res = {<<{sh_out}};
  end

  assign sra_res = sh_out | ({XLEN{req.op1[XLEN-1]}} & ~({XLEN{1'b1}} >> shamt));

  always_comb begin
    o_rsp.cmp_res = 1'b0;
    case (req.op)
      DP_ADD, DP_SUB: o_rsp.res = add_res[XLEN-1:0];
      DP_XOR:         o_rsp.res = xor_res;
      DP_SLL:         o_rsp.res = sll_res;
      DP_SRL:         o_rsp.res = sh_out;
      DP_SRA:         o_rsp.res = sra_res;
      DP_OR:          o_rsp.res = req.op1 | req.op2;
      DP_AND:         o_rsp.res = req.op1 & req.op2;
      DP_SLT, DP_SLTU: o_rsp.res = XLEN'(lt);
      DP_LUI:         o_rsp.res = req.op2;
      default:        o_rsp.res = add_res[XLEN-1:0];   // Compares
    endcase
    case (req.op)
      DP_CMP_EQ:              o_rsp.cmp_res = eq;
      DP_CMP_NE:              o_rsp.cmp_res = ~eq;
      DP_CMP_LT, DP_CMP_LTU:  o_rsp.cmp_res = lt;
      DP_CMP_GE, DP_CMP_GEU:  o_rsp.cmp_res = ~lt;
      default:                o_rsp.cmp_res = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/alu_pkg.sv ====
// ALU decode-level types
// Instruction groups, unit opcodes, datapath opcodes and the decode info record

`default_nettype none

package alu_pkg;

  // Which unit executes the instruction
  typedef enum logic [0:0] {
    GRP_ALU = 1'b0,
    GRP_BJP = 1'b1
  } grp_e;

  // Regular ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_SLT, ALU_SLTU, ALU_LUI,
    ALU_ECALL, ALU_EBREAK, ALU_WFI
  } alu_op_e;

  // Branch and jump operations
  typedef enum logic [2:0] {
    BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE,
    BJP_BLTU, BJP_BGEU, BJP_JUMP
  } bjp_op_e;

  //////////////////////////////
  // Shared datapath operations
  typedef enum logic [4:0] {
    DP_ADD, DP_SUB, DP_XOR, DP_SLL,
    DP_SRL, DP_SRA, DP_OR, DP_AND,
    DP_SLT, DP_SLTU, DP_LUI,
    DP_CMP_EQ, DP_CMP_NE, DP_CMP_LT,
    DP_CMP_GE, DP_CMP_LTU, DP_CMP_GEU
  } dpath_op_e;

  // Decode info handed over with each instruction
  typedef struct packed {
    grp_e    grp;
    logic    rv32;     // Clear for a 16-bit instruction
    alu_op_e alu_op;
    bjp_op_e bjp_op;
    logic    op2imm;   // Operand 2 from the immediate
    logic    bprdt;    // Branch predicted taken
  } dec_info_t;

endpackage

`default_nettype wire

// ==== source/alu_rglr.sv ====
// Regular ALU unit
// Chooses operand 2, requests the shared datapath and flags system ops

`default_nettype none

module alu_rglr import exu_pkg::*, alu_pkg::*; (
  input  wire             i_vld,
  input  wire issue_t     i_issue,
  output dpath_req_t      o_req,
  input  wire dpath_rsp_t i_rsp,
  output logic [XLEN-1:0] o_wdat,
  output logic            o_ecall,
  output logic            o_ebreak,
  output logic            o_wfi
);

  alu_op_e   op;
  dpath_op_e dp_op;
  logic      use_imm;

  assign op      = i_issue.info.alu_op;
  assign use_imm = i_issue.info.op2imm | (op == ALU_LUI);   // LUI always takes imm

  always_comb begin
    case (op)
      ALU_ADD:  dp_op = DP_ADD;
      ALU_SUB:  dp_op = DP_SUB;
      ALU_XOR:  dp_op = DP_XOR;
      ALU_SLL:  dp_op = DP_SLL;
      ALU_SRL:  dp_op = DP_SRL;
      ALU_SRA:  dp_op = DP_SRA;
      ALU_OR:   dp_op = DP_OR;
      ALU_AND:  dp_op = DP_AND;
      ALU_SLT:  dp_op = DP_SLT;
      ALU_SLTU: dp_op = DP_SLTU;
      ALU_LUI:  dp_op = DP_LUI;
      default:  dp_op = DP_ADD;   // System ops
    endcase
  end

  // Datapath only needed when rd gets written
  assign o_req.req = i_vld & i_issue.rdwen;
  assign o_req.op  = dp_op;
  assign o_req.op1 = i_issue.rs1;
  assign o_req.op2 = use_imm ? i_issue.imm : i_issue.rs2;

  assign o_wdat   = i_rsp.res;
  assign o_ecall  = i_vld & (op == ALU_ECALL);
  assign o_ebreak = i_vld & (op == ALU_EBREAK);
  assign o_wfi    = i_vld & (op == ALU_WFI);

endmodule

`default_nettype wire

// ==== source/exu_alu.sv ====
// Execute-stage ALU
// Ties dispatch, the regular and branch units and the shared datapath together

`default_nettype none

module exu_alu import exu_pkg::*; (
  input  wire         clk,        // Checker sampling only, block is combinational
  input  wire         i_rst_n,
  input  wire         i_valid,
  output logic        o_ready,
  input  wire issue_t i_issue,
  output logic        o_cmt_valid,
  input  wire         i_cmt_ready,
  output cmt_t        o_cmt,
  output logic        o_wbck_valid,
  input  wire         i_wbck_ready,
  output wbck_t       o_wbck
);

  logic            alu_vld;
  logic            bjp_vld;
  logic [XLEN-1:0] alu_wdat;
  logic            alu_ecall;
  logic            alu_ebreak;
  logic            alu_wfi;
  logic [XLEN-1:0] bjp_wdat;
  logic            bjp_bjp;
  logic            bjp_rslv;
  dpath_req_t      rglr_req;
  dpath_req_t      bjp_req;
  dpath_rsp_t      dpath_rsp;

  alu_dispatch u_dispatch (
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_issue      (i_issue),
    .o_alu_vld    (alu_vld),
    .o_bjp_vld    (bjp_vld),
    .i_alu_wdat   (alu_wdat),
    .i_alu_ecall  (alu_ecall),
    .i_alu_ebreak (alu_ebreak),
    .i_alu_wfi    (alu_wfi),
    .i_bjp_wdat   (bjp_wdat),
    .i_bjp_bjp    (bjp_bjp),
    .i_bjp_rslv   (bjp_rslv),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  alu_rglr u_rglr (
    .i_vld    (alu_vld),
    .i_issue  (i_issue),
    .o_req    (rglr_req),
    .i_rsp    (dpath_rsp),
    .o_wdat   (alu_wdat),
    .o_ecall  (alu_ecall),
    .o_ebreak (alu_ebreak),
    .o_wfi    (alu_wfi)
  );

  alu_bjp u_bjp (
    .i_vld   (bjp_vld),
    .i_issue (i_issue),
    .o_req   (bjp_req),
    .i_rsp   (dpath_rsp),
    .o_wdat  (bjp_wdat),
    .o_bjp   (bjp_bjp),
    .o_rslv  (bjp_rslv)
  );

  alu_dpath u_dpath (
    .i_rglr_req (rglr_req),
    .i_bjp_req  (bjp_req),
    .o_rsp      (dpath_rsp)
  );

endmodule

`default_nettype wire

// ==== source/exu_pkg.sv ====
// Execute-stage port types
// RV32 widths plus the issue, datapath, commit and write-back records

`default_nettype none

package exu_pkg;

  import alu_pkg::*;

  localparam int XLEN        = 32;
  localparam int PC_SIZE     = 32;
  localparam int RFIDX_WIDTH = 5;

  typedef struct packed {
    logic [XLEN-1:0]        rs1;
    logic [XLEN-1:0]        rs2;
    logic [XLEN-1:0]        imm;
    dec_info_t              info;
    logic [PC_SIZE-1:0]     pc;
    logic                   pc_vld;
    logic [RFIDX_WIDTH-1:0] rdidx;
    logic                   rdwen;
    logic                   ilegl;    // Fetch exceptions
    logic                   buserr;
    logic                   misalgn;
  } issue_t;

  //////////////////////////////
  // Datapath request and answer
  typedef struct packed {
    logic            req;
    dpath_op_e       op;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
  } dpath_req_t;

  typedef struct packed {
    logic [XLEN-1:0] res;
    logic            cmp_res;
  } dpath_rsp_t;

  typedef struct packed {
    logic [PC_SIZE-1:0] pc;
    logic               pc_vld;
    logic [XLEN-1:0]    imm;
    logic               rv32;
    logic               bjp;
    logic               bjp_prdt;
    logic               bjp_rslv;
    logic               ecall;
    logic               ebreak;
    logic               wfi;
    logic               ifu_misalgn;
    logic               ifu_buserr;
    logic               ifu_ilegl;
  } cmt_t;

  typedef struct packed {
    logic [XLEN-1:0]        wdat;
    logic [RFIDX_WIDTH-1:0] rdidx;
  } wbck_t;

endpackage

`default_nettype wire

// ==== tb.f ====
source/alu_pkg.sv
source/exu_pkg.sv
source/alu_dpath.sv
source/alu_rglr.sv
source/alu_bjp.sv
source/alu_dispatch.sv
source/exu_alu.sv
bench/tb_clkgen.sv
bench/exu_alu_checker.sv
bench/tb_exu_alu.sv
